// File: Makefile
TOP := tb_cpu8

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f cpu8.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: cpu8.f
cpu8_pkg.sv
cpu8_alu.sv
cpu8_flags.sv
cpu8_pc.sv
cpu8_regfile.sv
cpu8_sequencer.sv
cpu8_core.sv
tb_clock.sv
cpu8_sva.sv
tb_cpu8.sv

// File: cpu8_alu.sv
`timescale 1ns/1ps

module cpu8_alu import cpu8_pkg::*; (
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b_reg,
    input  logic [data_w-1:0] b_imm,

    input  logic              alu_use_imm,
    input  alu_op_t           alu_op,
    input  logic              carry_in,

    output logic [data_w-1:0] result,
    output logic              zero,
    output logic              carry
);

    logic [data_w-1:0] b;
    logic [data_w:0]   sum;  // Bit 8 is carry or borrow
    logic [data_w:0]   a_ext;
    logic [data_w:0]   b_ext;
    logic [data_w:0]   c_ext;

    assign b     = alu_use_imm ? b_imm : b_reg;
    assign a_ext = {1'b0, a};
    assign b_ext = {1'b0, b};
    assign c_ext = {{data_w{1'b0}}, carry_in};

    always_comb
    begin
        case (alu_op)
            alu_add: sum = a_ext + b_ext;
            alu_adc: sum = a_ext + b_ext + c_ext;
            alu_sub: sum = a_ext - b_ext;
            alu_sbc: sum = a_ext - b_ext - c_ext;
            alu_and: sum = {1'b0, a & b};
            alu_xor: sum = {1'b0, a ^ b};
            alu_or:  sum = {1'b0, a | b};
            default: sum = a_ext - b_ext;  // CP
        endcase
    end

    assign result = sum[data_w-1:0];
    assign carry  = sum[data_w];
    assign zero   = result == '0;

endmodule

// File: cpu8_core.sv
`timescale 1ns/1ps

module cpu8_core import cpu8_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    output logic [addr_w-1:0] mem_addr,
    output logic              mem_rd,
    input  logic [data_w-1:0] mem_rdata,
    output logic              mem_wr,
    output logic [data_w-1:0] mem_wdata,

    output logic              halted
);

    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] hl;
    logic              pc_inc;
    logic              target_lo_load;
    logic              pc_load;

    reg_code_t         rd_sel;
    reg_code_t         wr_sel;
    logic              wr_en;
    wr_src_t           wr_src;
    logic [data_w-1:0] rd_a;
    logic [data_w-1:0] rd_b;

    alu_op_t           alu_op;
    logic              alu_use_imm;
    logic [data_w-1:0] result;
    logic              zero;
    logic              carry;

    logic              flags_load;
    cond_t             cond;
    logic              carry_in;
    logic              cond_true;

    assign mem_wdata = rd_b;  // Only LD (HL),r writes

    cpu8_sequencer cpu8_sequencer_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .mem_rdata      (mem_rdata),
        .pc             (pc),
        .hl             (hl),
        .cond_true      (cond_true),
        .mem_addr       (mem_addr),
        .mem_rd         (mem_rd),
        .mem_wr         (mem_wr),
        .halted         (halted),
        .pc_inc         (pc_inc),
        .target_lo_load (target_lo_load),
        .pc_load        (pc_load),
        .rd_sel         (rd_sel),
        .wr_sel         (wr_sel),
        .wr_en          (wr_en),
        .wr_src         (wr_src),
        .alu_op         (alu_op),
        .alu_use_imm    (alu_use_imm),
        .flags_load     (flags_load),
        .cond           (cond)
    );

    cpu8_pc cpu8_pc_inst (
        .clock          (clock),
        .rst_n          (rst_n),
        .mem_rdata      (mem_rdata),
        .pc_inc         (pc_inc),
        .target_lo_load (target_lo_load),
        .pc_load        (pc_load),
        .pc             (pc)
    );

    cpu8_regfile cpu8_regfile_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .rd_sel     (rd_sel),
        .wr_sel     (wr_sel),
        .wr_en      (wr_en),
        .wr_src     (wr_src),
        .alu_result (result),
        .mem_rdata  (mem_rdata),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .hl         (hl)
    );

    cpu8_alu cpu8_alu_inst (
        .a           (rd_a),
        .b_reg       (rd_b),
        .b_imm       (mem_rdata),
        .alu_use_imm (alu_use_imm),
        .alu_op      (alu_op),
        .carry_in    (carry_in),
        .result      (result),
        .zero        (zero),
        .carry       (carry)
    );

    cpu8_flags cpu8_flags_inst (
        .clock      (clock),
        .rst_n      (rst_n),
        .flags_load (flags_load),
        .zero       (zero),
        .carry      (carry),
        .cond       (cond),
        .carry_in   (carry_in),
        .cond_true  (cond_true)
    );

endmodule

// File: cpu8_flags.sv
`timescale 1ns/1ps

module cpu8_flags import cpu8_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,

    input  logic  flags_load,
    input  logic  zero,
    input  logic  carry,
    input  cond_t cond,

    output logic  carry_in,
    output logic  cond_true
);

    logic flag_z;
    logic flag_c;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end
        else if (flags_load)
        begin
            flag_z <= zero;
            flag_c <= carry;
        end
    end

    assign carry_in = flag_c;

    always_comb
    begin
        case (cond)
            cond_nz: cond_true = !flag_z;
            cond_z:  cond_true = flag_z;
            cond_nc: cond_true = !flag_c;
            default: cond_true = flag_c;
        endcase
    end

endmodule

// File: cpu8_pc.sv
`timescale 1ns/1ps

module cpu8_pc import cpu8_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    input  logic [data_w-1:0] mem_rdata,

    input  logic              pc_inc,
    input  logic              target_lo_load,
    input  logic              pc_load,

    output logic [addr_w-1:0] pc
);

    logic [data_w-1:0] target_lo;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            pc <= '0;
        else if (pc_load)
            pc <= {mem_rdata, target_lo};  // High byte arrives last
        else if (pc_inc)
            pc <= pc + 16'd1;
    end

    always_ff @(posedge clock)
    begin
        if (target_lo_load)
            target_lo <= mem_rdata;
    end

endmodule

// File: cpu8_pkg.sv
package cpu8_pkg;

    localparam int data_w = 8;
    localparam int addr_w = 16;

    // Register codes as found in opcode fields y and z
    typedef logic [2:0] reg_code_t;

    localparam reg_code_t reg_b = 3'd0;
    localparam reg_code_t reg_c = 3'd1;
    localparam reg_code_t reg_d = 3'd2;
    localparam reg_code_t reg_e = 3'd3;
    localparam reg_code_t reg_h = 3'd4;
    localparam reg_code_t reg_l = 3'd5;
    localparam reg_code_t reg_m = 3'd6;  // Memory at HL
    localparam reg_code_t reg_a = 3'd7;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_and,
        alu_xor,
        alu_or,
        alu_cp
    } alu_op_t;

    typedef enum logic [1:0] {
        cond_nz,
        cond_z,
        cond_nc,
        cond_c
    } cond_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_jump_hi,
        st_halt
    } state_t;

    typedef enum logic [1:0] {
        src_alu,
        src_mem,
        src_reg
    } wr_src_t;

    // Group, destination or ALU op, source
    typedef struct packed {
        logic [1:0] x;
        logic [2:0] y;
        logic [2:0] z;
    } instr_rr_t;

    // Conditional jump layout
    typedef struct packed {
        logic [1:0] x;
        logic       spare;
        cond_t      cc;
        logic [2:0] z;
    } instr_cond_t;

    typedef union packed {
        instr_rr_t   rr;
        instr_cond_t cnd;
    } instr_t;

    localparam logic [7:0] op_jp         = 8'hC3;
    localparam logic [7:0] op_halt       = 8'h76;
    localparam logic [7:0] op_jp_cc_base = 8'hC2;

    localparam logic [1:0] grp_misc_lo = 2'd0;  // NOP, LD r,n
    localparam logic [1:0] grp_ld      = 2'd1;
    localparam logic [1:0] grp_alu     = 2'd2;
    localparam logic [1:0] grp_misc_hi = 2'd3;  // JP, ALU n

    localparam logic [2:0] z_imm = 3'd6;
    localparam logic [2:0] z_jp  = 3'd2;

endpackage

// File: cpu8_regfile.sv
`timescale 1ns/1ps

module cpu8_regfile import cpu8_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    input  reg_code_t         rd_sel,
    input  reg_code_t         wr_sel,
    input  logic              wr_en,
    input  wr_src_t           wr_src,

    input  logic [data_w-1:0] alu_result,
    input  logic [data_w-1:0] mem_rdata,

    output logic [data_w-1:0] rd_a,
    output logic [data_w-1:0] rd_b,
    output logic [addr_w-1:0] hl
);

    logic [data_w-1:0] b, c, d, e, h, l, a;
    logic [data_w-1:0] wr_data;

    always_comb
    begin
        case (wr_src)
            src_alu: wr_data = alu_result;
            src_mem: wr_data = mem_rdata;
            default: wr_data = rd_b;  // Register move
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            b <= '0;
            c <= '0;
            d <= '0;
            e <= '0;
            h <= '0;
            l <= '0;
            a <= '0;
        end
        else if (wr_en)
        begin
            case (wr_sel)
                reg_b:   b <= wr_data;
                reg_c:   c <= wr_data;
                reg_d:   d <= wr_data;
                reg_e:   e <= wr_data;
                reg_h:   h <= wr_data;
                reg_l:   l <= wr_data;
                reg_a:   a <= wr_data;
                default: ;
            endcase
        end
    end

    always_comb
    begin
        case (rd_sel)
            reg_b:   rd_b = b;
            reg_c:   rd_b = c;
            reg_d:   rd_b = d;
            reg_e:   rd_b = e;
            reg_h:   rd_b = h;
            reg_l:   rd_b = l;
            reg_a:   rd_b = a;
            default: rd_b = '0;
        endcase
    end

    assign rd_a = a;
    assign hl   = {h, l};

endmodule

// File: cpu8_sequencer.sv
`timescale 1ns/1ps

module cpu8_sequencer import cpu8_pkg::*; (
    input  logic              clock,
    input  logic              rst_n,

    input  logic [data_w-1:0] mem_rdata,
    input  logic [addr_w-1:0] pc,
    input  logic [addr_w-1:0] hl,
    input  logic              cond_true,

    output logic [addr_w-1:0] mem_addr,
    output logic              mem_rd,
    output logic              mem_wr,
    output logic              halted,

    output logic              pc_inc,
    output logic              target_lo_load,
    output logic              pc_load,

    output reg_code_t         rd_sel,
    output reg_code_t         wr_sel,
    output logic              wr_en,
    output wr_src_t           wr_src,

    output alu_op_t           alu_op,
    output logic              alu_use_imm,
    output logic              flags_load,
    output cond_t             cond
);

    state_t state;
    state_t state_next;
    instr_t instr;

    logic   rd_req;
    logic   wr_req;
    logic   addr_hl;

    logic   is_ld_rr;
    logic   is_ld_r_hl;
    logic   is_ld_hl_r;
    logic   is_ld_r_n;
    logic   is_alu_r;
    logic   is_alu_n;
    logic   is_jp;
    logic   is_jp_cc;

    always_ff @(posedge clock)
    begin
        if (!rst_n)
            state <= st_fetch;
        else
            state <= state_next;
    end

    always_ff @(posedge clock)
    begin
        if (state == st_fetch)
            instr <= mem_rdata;
    end

    // Decode from the rr view
    assign is_ld_rr   = instr.rr.x == grp_ld && instr.rr.y != reg_m && instr.rr.z != reg_m;
    assign is_ld_r_hl = instr.rr.x == grp_ld && instr.rr.y != reg_m && instr.rr.z == reg_m;
    assign is_ld_hl_r = instr.rr.x == grp_ld && instr.rr.y == reg_m && instr.rr.z != reg_m;
    assign is_ld_r_n  = instr.rr.x == grp_misc_lo && instr.rr.y != reg_m && instr.rr.z == z_imm;
    assign is_alu_r   = instr.rr.x == grp_alu && instr.rr.z != reg_m;
    assign is_alu_n   = instr.rr.x == grp_misc_hi && instr.rr.z == z_imm;
    assign is_jp      = instr == op_jp;

    // C2, CA, D2, DA
    assign is_jp_cc = {instr.cnd.x, instr.cnd.spare} == op_jp_cc_base[7:5]
                      && instr.cnd.z == z_jp;

    assign rd_sel = instr.rr.z;
    assign alu_op = alu_op_t'(instr.rr.y);
    assign cond   = instr.cnd.cc;

    always_comb
    begin
        state_next     = state;
        rd_req         = 1'b0;
        wr_req         = 1'b0;
        addr_hl        = 1'b0;
        pc_inc         = 1'b0;
        target_lo_load = 1'b0;
        pc_load        = 1'b0;
        wr_sel         = instr.rr.y;
        wr_en          = 1'b0;
        wr_src         = src_reg;
        alu_use_imm    = 1'b0;
        flags_load     = 1'b0;

        case (state)
            st_fetch:
            begin
                rd_req     = 1'b1;
                pc_inc     = 1'b1;
                state_next = (mem_rdata == op_halt) ? st_halt : st_exec;
            end
            st_exec:
            begin
                state_next = st_fetch;
                if (is_ld_rr)
                begin
                    wr_en = 1'b1;
                end
                else if (is_ld_r_hl || is_ld_r_n)
                begin
                    rd_req  = 1'b1;
                    addr_hl = is_ld_r_hl;
                    pc_inc  = is_ld_r_n;  // Immediate byte
                    wr_src  = src_mem;
                    wr_en   = 1'b1;
                end
                else if (is_ld_hl_r)
                begin
                    wr_req  = 1'b1;
                    addr_hl = 1'b1;
                end
                else if (is_alu_r || is_alu_n)
                begin
                    rd_req      = is_alu_n;
                    pc_inc      = is_alu_n;
                    alu_use_imm = is_alu_n;
                    wr_sel      = reg_a;
                    wr_src      = src_alu;
                    wr_en       = alu_op != alu_cp;  // CP only sets flags
                    flags_load  = 1'b1;
                end
                else if (is_jp || is_jp_cc)
                begin
                    rd_req         = 1'b1;
                    pc_inc         = 1'b1;
                    target_lo_load = 1'b1;
                    state_next     = st_jump_hi;
                end
            end
            st_jump_hi:
            begin
                rd_req     = 1'b1;
                pc_inc     = 1'b1;
                pc_load    = is_jp || cond_true;
                state_next = st_fetch;
            end
            default: ;  // Halted until reset
        endcase
    end

    assign mem_addr = addr_hl ? hl : pc;

    // No bus traffic while held in reset
    assign mem_rd = rd_req && rst_n;
    assign mem_wr = wr_req && rst_n;
    assign halted = state == st_halt;

endmodule

// File: cpu8_sva.sv
`timescale 1ns/1ps

module cpu8_sva (
    input logic clock,
    input logic rst_n,
    input logic mem_rd,
    input logic mem_wr,
    input logic halted
);

    // Read and write share one address bus
    a_rd_wr_exclusive: assert property (@(posedge clock) !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr high in the same cycle");

    a_quiet_when_halted: assert property (@(posedge clock) halted |-> !mem_rd && !mem_wr)
        else $error("bus access while halted");

    // Only reset leaves the halt state
    a_halt_sticky: assert property (@(posedge clock) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind cpu8_core cpu8_sva cpu8_sva_inst (
    .clock  (clock),
    .rst_n  (rst_n),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .halted (halted)
);

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clock
);

    initial
    begin
        clock = 1'b0;
        forever #20 clock = ~clock;  // 40 ns period
    end

endmodule

// File: tb_cpu8.sv
`timescale 1ns/1ps

module tb_cpu8 import cpu8_pkg::*; ();

    logic              clock;
    logic              rst_n;
    logic [addr_w-1:0] mem_addr;
    logic              mem_rd;
    logic [data_w-1:0] mem_rdata;
    logic              mem_wr;
    logic [data_w-1:0] mem_wdata;
    logic              halted;

    logic [7:0]  mem [0:65535];        // Memory the DUT sees
    logic [7:0]  model_mem [0:65535];  // Program image that the model later updates

    logic [31:0] lcg_state;
    logic [15:0] gen_addr;
    int          prog_instrs;

    // Expected bus accesses in order
    logic        exp_wr [$];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    int          exp_halt_cycle;

    logic        next_wr;
    logic [15:0] next_addr;
    logic [7:0]  next_data;

    int   cyc = 0;
    int   reset_cycles = 0;
    logic halt_seen = 1'b0;
    int   limit;
    int   check_errors = 0;
    int   bus_errors = 0;
    int   timeout_errors = 0;

    tb_clock tb_clock_inst (.clock(clock));

    cpu8_core cpu8_core_inst (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_addr  (mem_addr),
        .mem_rd    (mem_rd),
        .mem_rdata (mem_rdata),
        .mem_wr    (mem_wr),
        .mem_wdata (mem_wdata),
        .halted    (halted)
    );

    assign mem_rdata = mem[mem_addr];  // Asynchronous read

    always @(posedge clock)
    begin
        if (mem_wr)
            mem[mem_addr] <= mem_wdata;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r >> 8) % n;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    // Never H, so HL stays inside the data page
    function automatic logic [2:0] pick_dest();
        int r;
        r = rand_below(6);
        if (r == 4)
            return reg_l;
        if (r == 5)
            return reg_a;
        return 3'(r);
    endfunction

    function automatic logic [2:0] pick_src();
        int r;
        r = rand_below(7);
        return (r == 6) ? reg_a : 3'(r);
    endfunction

    task automatic place_byte(input logic [7:0] value);
        model_mem[gen_addr] = value;
        gen_addr = gen_addr + 16'd1;
    endtask

    task automatic build_program();
        logic [15:0] start [0:150];
        logic [15:0] patch_at [0:149];
        int          dest_idx [0:149];
        logic [15:0] target;
        logic [2:0]  dst;
        logic [2:0]  src;
        int          kind;
        int          jp;
        for (int i = 0; i < 65536; i++)
            model_mem[i] = rand_byte();
        gen_addr = 16'h0000;
        place_byte({2'b00, reg_h, 3'b110});  // LD H,80h
        place_byte(8'h80);
        for (int k = 0; k < 150; k++)
        begin
            start[k] = gen_addr;
            dest_idx[k] = -1;
            kind = rand_below(9);
            case (kind)
                0:
                begin
                    dst = pick_dest();
                    src = pick_src();
                    place_byte({2'b01, dst, src});
                end
                1:
                begin
                    dst = pick_dest();
                    place_byte({2'b00, dst, 3'b110});
                    place_byte(rand_byte());
                end
                2:
                begin
                    dst = pick_dest();
                    place_byte({2'b01, dst, reg_m});
                end
                3:
                begin
                    src = pick_src();
                    place_byte({2'b01, reg_m, src});
                end
                4, 5:
                begin
                    src = pick_src();
                    place_byte({2'b10, 3'(rand_below(8)), src});
                end
                6:
                begin
                    place_byte({2'b11, 3'(rand_below(8)), 3'b110});
                    place_byte(rand_byte());
                end
                7:
                begin
                    jp = rand_below(5);
                    if (jp == 0)
                        place_byte(op_jp);
                    else
                        place_byte(op_jp_cc_base | {3'b000, 2'(jp - 1), 3'b000});
                    patch_at[k] = gen_addr;
                    dest_idx[k] = k + 1 + rand_below(150 - k);  // Forward only
                    place_byte(8'h00);
                    place_byte(8'h00);
                end
                default: place_byte(8'h00);
            endcase
        end
        start[150] = gen_addr;
        for (int r = 0; r < 8; r++)
        begin
            if (r != 6)
                place_byte({5'b01110, 3'(r)});  // LD (HL),r
        end
        place_byte(op_halt);
        prog_instrs = 1 + 150 + 7 + 1;
        for (int k = 0; k < 150; k++)
        begin
            if (dest_idx[k] >= 0)
            begin
                target = start[dest_idx[k]];
                model_mem[patch_at[k]] = target[7:0];
                model_mem[patch_at[k] + 16'd1] = target[15:8];
            end
        end
    endtask

    task automatic expect_access(input logic is_write, input logic [15:0] addr,
                                 input logic [7:0] data);
        exp_wr.push_back(is_write);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Bit 8 is the add carry or the subtract borrow
    function automatic logic [8:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                             input logic [7:0] b, input logic cin);
        int ai;
        int bi;
        int ci;
        int t;
        ai = int'(a);
        bi = int'(b);
        ci = cin ? 1 : 0;
        case (op)
            3'd0: t = ai + bi;
            3'd1: t = ai + bi + ci;
            3'd3: t = ai - bi - ci;
            3'd4: return {1'b0, a & b};
            3'd5: return {1'b0, a ^ b};
            3'd6: return {1'b0, a | b};
            default: t = ai - bi;  // SUB and CP
        endcase
        return {t > 255 || t < 0, t[7:0]};
    endfunction

    task automatic run_model();
        logic [7:0]  regs [0:7];
        logic [15:0] pc;
        logic [15:0] hl;
        logic [7:0]  op;
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [8:0]  r;
        logic        fz;
        logic        fc;
        logic        taken;
        int          cycles;
        int          steps;
        for (int i = 0; i < 8; i++)
            regs[i] = 8'h00;
        pc = 16'h0000;
        fz = 1'b0;
        fc = 1'b0;
        cycles = 0;
        steps = 0;
        exp_halt_cycle = -1;
        while (exp_halt_cycle < 0 && steps < prog_instrs)
        begin
            steps++;
            op = model_mem[pc];
            expect_access(1'b0, pc, 8'h00);
            pc = pc + 16'd1;
            cycles = cycles + 2;
            hl = {regs[reg_h], regs[reg_l]};
            if (op == op_halt)
                exp_halt_cycle = cycles - 1;  // Halt state right after the fetch
            else if (op[7:6] == 2'b01)
            begin
                if (op[5:3] == reg_m)
                begin
                    expect_access(1'b1, hl, regs[op[2:0]]);
                    model_mem[hl] = regs[op[2:0]];
                end
                else if (op[2:0] == reg_m)
                begin
                    expect_access(1'b0, hl, 8'h00);
                    regs[op[5:3]] = model_mem[hl];
                end
                else
                    regs[op[5:3]] = regs[op[2:0]];
            end
            else if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != reg_m)
            begin
                expect_access(1'b0, pc, 8'h00);
                regs[op[5:3]] = model_mem[pc];
                pc = pc + 16'd1;
            end
            else if ((op[7:6] == 2'b10 && op[2:0] != reg_m)
                     || (op[7:6] == 2'b11 && op[2:0] == 3'b110))
            begin
                if (op[7:6] == 2'b11)
                begin
                    expect_access(1'b0, pc, 8'h00);
                    r = alu_model(op[5:3], regs[reg_a], model_mem[pc], fc);
                    pc = pc + 16'd1;
                end
                else
                    r = alu_model(op[5:3], regs[reg_a], regs[op[2:0]], fc);
                fz = r[7:0] == 8'h00;
                fc = r[8];
                if (op[5:3] != 3'd7)
                    regs[reg_a] = r[7:0];  // CP keeps A
            end
            else if (op == op_jp || op == 8'hC2 || op == 8'hCA || op == 8'hD2 || op == 8'hDA)
            begin
                expect_access(1'b0, pc, 8'h00);
                lo = model_mem[pc];
                expect_access(1'b0, pc + 16'd1, 8'h00);
                hi = model_mem[pc + 16'd1];
                pc = pc + 16'd2;
                cycles++;
                case (op[4:3])
                    2'd0: taken = !fz;
                    2'd1: taken = fz;
                    2'd2: taken = !fc;
                    default: taken = fc;
                endcase
                if (op == op_jp || taken)
                    pc = {hi, lo};
            end
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, expected);
        check_errors++;
    endtask

    // Bus monitor sampled just before each rising edge
    always @(posedge clock)
    begin
        if (!rst_n)
        begin
            if (reset_cycles > 0)
            begin
                if (mem_rd !== 1'b0)
                    report_mismatch("mem_rd", 32'(mem_rd), 32'd0);
                if (mem_wr !== 1'b0)
                    report_mismatch("mem_wr", 32'(mem_wr), 32'd0);
                if (halted !== 1'b0)
                    report_mismatch("halted", 32'(halted), 32'd0);
            end
            reset_cycles++;
        end
        else
        begin
            if (mem_rd && mem_wr)
            begin
                $display("mem_rd and mem_wr both high at %0t", $time);
                bus_errors++;
            end
            if (halted && !halt_seen)
            begin
                halt_seen = 1'b1;
                if (cyc != exp_halt_cycle)
                    report_mismatch("halted rise cycle", 32'(cyc), 32'(exp_halt_cycle));
            end
            if (halt_seen && !halted)
            begin
                $display("halted fell without reset at %0t", $time);
                bus_errors++;
            end
            if (halt_seen && (mem_rd || mem_wr))
            begin
                $display("bus access while halted at %0t", $time);
                bus_errors++;
            end
            else if (mem_rd || mem_wr)
            begin
                if (exp_wr.size() == 0)
                begin
                    $display("bus access beyond the expected sequence at %0t", $time);
                    bus_errors++;
                end
                else
                begin
                    // First entry is the fetch at address 0
                    next_wr = exp_wr.pop_front();
                    next_addr = exp_addr.pop_front();
                    next_data = exp_data.pop_front();
                    if (mem_wr !== next_wr)
                        report_mismatch("mem_wr", 32'(mem_wr), 32'(next_wr));
                    if (mem_addr !== next_addr)
                        report_mismatch("mem_addr", 32'(mem_addr), 32'(next_addr));
                    if (next_wr && mem_wdata !== next_data)
                        report_mismatch("mem_wdata", 32'(mem_wdata), 32'(next_data));
                end
            end
            cyc++;
        end
    end

    initial
    begin
        rst_n = 1'b0;
        lcg_state = 32'h2b7f_7d08;
        build_program();
        for (int i = 0; i < 65536; i++)
            mem[i] <= model_mem[i];
        run_model();
        limit = 3 * prog_instrs + 50;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        while (!halt_seen && cyc < limit)
            @(negedge clock);
        if (!halt_seen)
        begin
            $display("timeout: halted did not rise within %0d cycles", limit);
            timeout_errors++;
        end
        else
        begin
            repeat (10) @(negedge clock);
            if (exp_wr.size() != 0)
            begin
                $display("%0d expected bus accesses never happened", exp_wr.size());
                bus_errors++;
            end
        end
        $display("errors: %0d value, %0d bus, %0d timeout",
                 check_errors, bus_errors, timeout_errors);
        if (check_errors + bus_errors + timeout_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
